/* logic/gather_pkg.sv */
package gather_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int CONTEXTS   = 4;
    localparam int CTXT_WID   = 2;
    localparam int PTR_WID    = 6;
    localparam int DESC_DEPTH = 64;
    localparam int SIZE_WID   = 8;
    localparam int META_WID   = 4;
    localparam int Q_DEPTH    = 4;

    // Descriptor read latency, acceptance to ack
    localparam int MEM_LAT = 2;

    // ----------------------------------------
    // Descriptor word layout
    // ----------------------------------------
    // Err in the LSB, next pointer at the top. Result words reuse the
    // same layout with the next pointer replaced by the buffer pointer
    localparam int DESC_ERR_BIT  = 0;
    localparam int DESC_META_LSB = DESC_ERR_BIT + 1;
    localparam int DESC_SIZE_LSB = DESC_META_LSB + META_WID;
    localparam int DESC_EOF_BIT  = DESC_SIZE_LSB + SIZE_WID;
    localparam int DESC_NXT_LSB  = DESC_EOF_BIT + 1;
    localparam int DESC_WID      = DESC_NXT_LSB + PTR_WID;

    // ----------------------------------------
    // Read FSM
    // ----------------------------------------
    typedef enum logic [1:0] {
        RESET,
        DISABLED,
        IDLE,
        READ
    } gather_state_t;

endpackage : gather_pkg

/* logic/gather_if.sv */
`timescale 1ns/1ps

// One context's load request and result stream
interface gather_if
    import gather_pkg::*;
();

    // Load request
    logic                req;
    logic                rdy;
    logic [PTR_WID-1:0]  ptr;

    // Result stream, one entry per buffer in the chain
    logic                vld;
    logic                ack;
    logic [PTR_WID-1:0]  buf_ptr;
    logic                eof;
    logic [SIZE_WID-1:0] size;
    logic [META_WID-1:0] meta;
    logic                err;

    modport client (
        output req,
        output ptr,
        output ack,
        input  rdy,
        input  vld,
        input  buf_ptr,
        input  eof,
        input  size,
        input  meta,
        input  err
    );

    modport engine (
        input  req,
        input  ptr,
        input  ack,
        output rdy,
        output vld,
        output buf_ptr,
        output eof,
        output size,
        output meta,
        output err
    );

endinterface : gather_if

/* logic/desc_rd_if.sv */
`timescale 1ns/1ps

// Descriptor memory read port
interface desc_rd_if
    import gather_pkg::*;
();

    logic                req;
    logic                rdy;
    logic [PTR_WID-1:0]  addr;
    logic                ack;
    logic [DESC_WID-1:0] data;

    modport controller (
        output req,
        output addr,
        input  rdy,
        input  ack,
        input  data
    );

    modport peripheral (
        input  req,
        input  addr,
        output rdy,
        output ack,
        output data
    );

endinterface : desc_rd_if

/* logic/ctxt_fifo.sv */
`timescale 1ns/1ps

module ctxt_fifo #(
    parameter int DATA_WID = 8,
    parameter int DEPTH    = 4
) (
    input  logic                clk,
    input  logic                srst,

    input  logic                wr,
    input  logic [DATA_WID-1:0] wr_data,
    output logic                wr_rdy,

    input  logic                rd,
    output logic                rd_vld,
    output logic [DATA_WID-1:0] rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WID-1:0] mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                wr_ok;
    logic                rd_ok;

    // Write when full and read when empty are dropped
    assign wr_ok = wr && wr_rdy;
    assign rd_ok = rd && rd_vld;

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_ok && !rd_ok) begin
                count <= count + 1'b1;
            end else if (rd_ok && !wr_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assign wr_rdy  = (count != CNT_W'(DEPTH));
    assign rd_vld  = (count != '0);
    // Head of queue shows through without a read
    assign rd_data = mem[rd_ptr];

endmodule : ctxt_fifo

/* logic/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter
    import gather_pkg::*;
(
    input  logic                clk,
    input  logic                srst,
    input  logic                en,
    input  logic [CONTEXTS-1:0] req,
    output logic [CONTEXTS-1:0] grant,
    output logic [CTXT_WID-1:0] sel
);

    // Last context that won
    logic [CTXT_WID-1:0] last;
    logic                found;

    // Search starts one past the last winner
    always_comb begin
        int idx;
        grant = '0;
        sel   = last;
        found = 1'b0;
        for (int i = 1; i <= CONTEXTS; i++) begin
            idx = (int'(last) + i) % CONTEXTS;
            if (!found && req[idx]) begin
                found = 1'b1;
                sel   = CTXT_WID'(idx);
            end
        end
        if (en && found) begin
            grant[sel] = 1'b1;
        end
    end

    // Rotate priority only when a grant is given
    always_ff @(posedge clk) begin
        if (srst) begin
            last <= CTXT_WID'(CONTEXTS - 1);
        end else if (en && found) begin
            last <= sel;
        end
    end

endmodule : rr_arbiter

/* logic/desc_mem.sv */
`timescale 1ns/1ps

module desc_mem
    import gather_pkg::*;
(
    input  logic                clk,
    input  logic                srst,

    desc_rd_if.peripheral       rd_port,

    input  logic                wr,
    input  logic [PTR_WID-1:0]  wr_addr,
    input  logic [DESC_WID-1:0] wr_data,
    output logic                init_done
);

    logic [DESC_WID-1:0] mem [DESC_DEPTH];
    logic [PTR_WID-1:0]  init_addr;

    // Read pipeline
    logic [MEM_LAT-1:0]  vld_pipe;
    logic [DESC_WID-1:0] data_pipe [MEM_LAT];

    // ----------------------------------------
    // Self-clear after reset
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            init_addr <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_addr <= init_addr + 1'b1;
            if (init_addr == PTR_WID'(DESC_DEPTH - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // Clearing owns the array until init_done
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[init_addr] <= '0;
        end else if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------
    assign rd_port.rdy = init_done;

    always_ff @(posedge clk) begin
        if (srst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[MEM_LAT-2:0], rd_port.req && rd_port.rdy};
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[rd_port.addr];
        for (int i = 1; i < MEM_LAT; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign rd_port.ack  = vld_pipe[MEM_LAT-1];
    assign rd_port.data = data_pipe[MEM_LAT-1];

endmodule : desc_mem

/* logic/alloc_gather_core.sv */
`timescale 1ns/1ps

module alloc_gather_core
    import gather_pkg::*;
(
    input  logic          clk,
    input  logic          srst,

    input  logic          en,

    gather_if.engine      gather [CONTEXTS],

    desc_rd_if.controller desc_rd,
    input  logic          init_done
);

    // ----------------------------------------
    // Signals
    // ----------------------------------------
    gather_state_t       state;
    gather_state_t       nxt_state;

    logic [CONTEXTS-1:0] pending;
    logic [CONTEXTS-1:0] res_wr_rdy;
    logic [CONTEXTS-1:0] elig;
    logic [CONTEXTS-1:0] grant;
    logic [CTXT_WID-1:0] sel;
    logic [PTR_WID-1:0]  cur_ptr [CONTEXTS];

    logic                arb;
    logic                rd_req;
    logic                started;

    // Captured at arbitration, held through READ
    logic [CTXT_WID-1:0] rd_sel;
    logic [PTR_WID-1:0]  rd_ptr;

    // Context of the descriptor coming back
    logic [CTXT_WID-1:0] rd_ctxt;

    logic                desc_eof;
    logic [PTR_WID-1:0]  desc_nxt;

    assign desc_eof = desc_rd.data[DESC_EOF_BIT];
    assign desc_nxt = desc_rd.data[DESC_NXT_LSB +: PTR_WID];
    assign started  = (state != RESET);

    // ----------------------------------------
    // Per-context chain state
    // ----------------------------------------
    for (genvar g = 0; g < CONTEXTS; g++) begin : g_ctxt
        logic                load_busy;
        logic                accept;
        logic                rd_done;
        logic [DESC_WID-1:0] res_in;
        logic [DESC_WID-1:0] res_out;

        assign accept  = gather[g].req && gather[g].rdy;
        assign rd_done = desc_rd.ack && (rd_ctxt == CTXT_WID'(g));

        // Busy from load until the eof descriptor is back
        always_ff @(posedge clk) begin
            if (srst) begin
                load_busy <= 1'b0;
            end else if (accept) begin
                load_busy <= 1'b1;
            end else if (rd_done && desc_eof) begin
                load_busy <= 1'b0;
            end
        end

        assign gather[g].rdy = started && !load_busy;

        always_ff @(posedge clk) begin
            if (srst) begin
                pending[g] <= 1'b0;
            end else if (accept || (rd_done && !desc_eof)) begin
                pending[g] <= 1'b1;
            end else if (grant[g]) begin
                pending[g] <= 1'b0;
            end
        end

        // Follow the link; old value still names the buffer just read
        always_ff @(posedge clk) begin
            if (accept) begin
                cur_ptr[g] <= gather[g].ptr;
            end else if (rd_done) begin
                cur_ptr[g] <= desc_nxt;
            end
        end

        // At most one read in flight, so wr_rdy here reserves the slot
        assign elig[g] = pending[g] && res_wr_rdy[g];

        assign res_in = {cur_ptr[g], desc_rd.data[DESC_NXT_LSB-1:0]};

        ctxt_fifo #(
            .DATA_WID ( DESC_WID ),
            .DEPTH    ( Q_DEPTH )
        ) i_res_fifo (
            .clk,
            .srst,
            .wr      ( rd_done ),
            .wr_data ( res_in ),
            .wr_rdy  ( res_wr_rdy[g] ),
            .rd      ( gather[g].ack ),
            .rd_vld  ( gather[g].vld ),
            .rd_data ( res_out )
        );

        assign gather[g].buf_ptr = res_out[DESC_NXT_LSB +: PTR_WID];
        assign gather[g].eof     = res_out[DESC_EOF_BIT];
        assign gather[g].size    = res_out[DESC_SIZE_LSB +: SIZE_WID];
        assign gather[g].meta    = res_out[DESC_META_LSB +: META_WID];
        assign gather[g].err     = res_out[DESC_ERR_BIT];
    end : g_ctxt

    // ----------------------------------------
    // Read FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        arb       = 1'b0;
        rd_req    = 1'b0;
        case (state)
            RESET: begin
                if (init_done) begin
                    nxt_state = en ? IDLE : DISABLED;
                end
            end
            DISABLED: begin
                if (en) begin
                    nxt_state = IDLE;
                end
            end
            IDLE: begin
                if (!en) begin
                    nxt_state = DISABLED;
                end else begin
                    arb = 1'b1;
                    if (|elig) begin
                        nxt_state = READ;
                    end
                end
            end
            READ: begin
                // Hold req until accepted
                rd_req = 1'b1;
                if (desc_rd.rdy) begin
                    nxt_state = IDLE;
                end
            end
            default: begin
                nxt_state = RESET;
            end
        endcase
    end

    rr_arbiter i_arb (
        .clk,
        .srst,
        .en    ( arb ),
        .req   ( elig ),
        .grant ( grant ),
        .sel   ( sel )
    );

    always_ff @(posedge clk) begin
        if (arb && |elig) begin
            rd_sel <= sel;
            rd_ptr <= cur_ptr[sel];
        end
    end

    // Steers returned descriptors, popped by ack
    ctxt_fifo #(
        .DATA_WID ( CTXT_WID ),
        .DEPTH    ( CONTEXTS )
    ) i_rd_ctxt_fifo (
        .clk,
        .srst,
        .wr      ( rd_req && desc_rd.rdy ),
        .wr_data ( rd_sel ),
        .wr_rdy  ( ),
        .rd      ( desc_rd.ack ),
        .rd_vld  ( ),
        .rd_data ( rd_ctxt )
    );

    assign desc_rd.req  = rd_req;
    assign desc_rd.addr = rd_ptr;

endmodule : alloc_gather_core

/* logic/gather_top.sv */
`timescale 1ns/1ps

module gather_top
    import gather_pkg::*;
(
    input  logic                         clk,
    input  logic                         srst,
    input  logic                         en,

    // Load requests, one per context
    input  logic [CONTEXTS-1:0]          gather_req,
    input  logic [CONTEXTS*PTR_WID-1:0]  gather_ptr,
    output logic [CONTEXTS-1:0]          gather_rdy,

    // Results, one stream per context
    output logic [CONTEXTS-1:0]          gather_vld,
    output logic [CONTEXTS*PTR_WID-1:0]  gather_buf_ptr,
    output logic [CONTEXTS-1:0]          gather_eof,
    output logic [CONTEXTS*SIZE_WID-1:0] gather_size,
    output logic [CONTEXTS*META_WID-1:0] gather_meta,
    output logic [CONTEXTS-1:0]          gather_err,
    input  logic [CONTEXTS-1:0]          gather_ack,

    // Descriptor load port
    input  logic                         desc_wr,
    input  logic [PTR_WID-1:0]           desc_wr_addr,
    input  logic [DESC_WID-1:0]          desc_wr_data,
    output logic                         init_done
);

    gather_if  gather_bus [CONTEXTS] ();
    desc_rd_if desc_rd ();

    // Flat vectors to the interface array
    for (genvar g = 0; g < CONTEXTS; g++) begin : g_map
        assign gather_bus[g].req = gather_req[g];
        assign gather_bus[g].ptr = gather_ptr[g*PTR_WID +: PTR_WID];
        assign gather_bus[g].ack = gather_ack[g];

        assign gather_rdy[g]                        = gather_bus[g].rdy;
        assign gather_vld[g]                        = gather_bus[g].vld;
        assign gather_buf_ptr[g*PTR_WID +: PTR_WID] = gather_bus[g].buf_ptr;
        assign gather_eof[g]                        = gather_bus[g].eof;
        assign gather_size[g*SIZE_WID +: SIZE_WID]  = gather_bus[g].size;
        assign gather_meta[g*META_WID +: META_WID]  = gather_bus[g].meta;
        assign gather_err[g]                        = gather_bus[g].err;
    end : g_map

    alloc_gather_core i_core (
        .clk,
        .srst,
        .en,
        .gather    ( gather_bus ),
        .desc_rd   ( desc_rd ),
        .init_done ( init_done )
    );

    desc_mem i_desc_mem (
        .clk,
        .srst,
        .rd_port   ( desc_rd ),
        .wr        ( desc_wr ),
        .wr_addr   ( desc_wr_addr ),
        .wr_data   ( desc_wr_data ),
        .init_done ( init_done )
    );

endmodule : gather_top

/* testbench/tb_gather_model.svh */
`ifndef TB_GATHER_MODEL_SVH
`define TB_GATHER_MODEL_SVH

// ----------------------------------------
// Reference model
// ----------------------------------------
localparam int EXP_DEPTH = 128;

// Mirror of every descriptor written through the load port
logic [DESC_WID-1:0] model_mem [DESC_DEPTH];

// Expected results per context, circular with free-running indices
logic [DESC_WID-1:0] exp_word [CONTEXTS][EXP_DEPTH];
int                  exp_wr   [CONTEXTS];
int                  exp_rd   [CONTEXTS];

function automatic void model_clear();
    for (int a = 0; a < DESC_DEPTH; a++) begin
        model_mem[a] = '0;
    end
    for (int c = 0; c < CONTEXTS; c++) begin
        exp_wr[c] = 0;
        exp_rd[c] = 0;
    end
endfunction

function automatic void model_write(input logic [PTR_WID-1:0] addr,
                                    input logic [DESC_WID-1:0] data);
    model_mem[addr] = data;
endfunction

// Walk a chain from its start; each result carries the address it was read from
function automatic void model_load(input int c, input logic [PTR_WID-1:0] start);
    logic [PTR_WID-1:0]  p;
    logic [DESC_WID-1:0] d;
    logic [DESC_WID-1:0] r;
    p = start;
    for (int n = 0; n < DESC_DEPTH; n++) begin
        d = model_mem[p];
        r = d;
        r[DESC_NXT_LSB +: PTR_WID] = p;
        exp_word[c][exp_wr[c] % EXP_DEPTH] = r;
        exp_wr[c]++;
        if (d[DESC_EOF_BIT]) begin
            break;
        end
        p = d[DESC_NXT_LSB +: PTR_WID];
    end
endfunction

function automatic int model_count(input int c);
    return exp_wr[c] - exp_rd[c];
endfunction

function automatic logic [DESC_WID-1:0] model_pop(input int c);
    logic [DESC_WID-1:0] w;
    w = exp_word[c][exp_rd[c] % EXP_DEPTH];
    exp_rd[c]++;
    return w;
endfunction

`endif

/* testbench/tb_gather.sv */
`timescale 1ns/1ps

module tb_gather
    import gather_pkg::*;
();

    // ----------------------------------------
    // Run limits
    // ----------------------------------------
    // Longest chains the tests can build, all tests together
    localparam int MAX_DESC    = 6 + 2 * 6 * CONTEXTS + 6 * CONTEXTS + 6 * CONTEXTS;
    localparam int TIMEOUT_CYC = MAX_DESC * 4 * CONTEXTS * (MEM_LAT + 2) + DESC_DEPTH + 1000;
    localparam int HOLD_CYC    = 120;
    localparam int SETTLE_CYC  = 4 * (MEM_LAT + 2);

    logic                         clk;
    logic                         srst;
    logic                         en;
    logic [CONTEXTS-1:0]          gather_req;
    logic [CONTEXTS*PTR_WID-1:0]  gather_ptr;
    logic [CONTEXTS-1:0]          gather_rdy;
    logic [CONTEXTS-1:0]          gather_vld;
    logic [CONTEXTS*PTR_WID-1:0]  gather_buf_ptr;
    logic [CONTEXTS-1:0]          gather_eof;
    logic [CONTEXTS*SIZE_WID-1:0] gather_size;
    logic [CONTEXTS*META_WID-1:0] gather_meta;
    logic [CONTEXTS-1:0]          gather_err;
    logic [CONTEXTS-1:0]          gather_ack;
    logic                         desc_wr;
    logic [PTR_WID-1:0]           desc_wr_addr;
    logic [DESC_WID-1:0]          desc_wr_data;
    logic                         init_done;

    // Stimulus and bookkeeping
    logic [31:0]         lfsr;
    int                  cycle_cnt;
    int                  errors;
    int                  err_start;
    int                  tests_failed;
    int                  results_seen;
    int                  load_cnt   [CONTEXTS];
    int                  load_idx   [CONTEXTS];
    int                  load_delay [CONTEXTS];
    int                  ack_mode   [CONTEXTS];
    int                  ack_hold   [CONTEXTS];
    logic [PTR_WID-1:0]  load_start [CONTEXTS][2];
    logic [CONTEXTS-1:0] just_acc;
    logic                used [DESC_DEPTH];

    `include "tb_gather_model.svh"

    gather_top i_dut (
        .clk,
        .srst,
        .en,
        .gather_req,
        .gather_ptr,
        .gather_rdy,
        .gather_vld,
        .gather_buf_ptr,
        .gather_eof,
        .gather_size,
        .gather_meta,
        .gather_err,
        .gather_ack,
        .desc_wr,
        .desc_wr_addr,
        .desc_wr_data,
        .init_done
    );

    always #10 clk = ~clk;

    // ----------------------------------------
    // Random numbers
    // ----------------------------------------
    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | 32'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // ----------------------------------------
    // Per-cycle driving and checking
    // ----------------------------------------
    task automatic drive_ack(input int c);
        if (ack_hold[c] > 0) begin
            ack_hold[c]--;
            gather_ack[c] = 1'b0;
        end else if (ack_mode[c] == 0) begin
            gather_ack[c] = 1'b1;
        end else begin
            gather_ack[c] = 1'(rand_bits(1));
        end
    endtask

    task automatic check_rdy(input int c, input logic r);
        logic chain_open;
        // Results still owed that the FIFO cannot be holding
        chain_open = model_count(c) > Q_DEPTH || (model_count(c) > 0 && !gather_vld[c]);
        if (just_acc[c] && r) begin
            flag_error($sformatf("context %0d rdy high right after a load was accepted", c));
        end else if (r && chain_open) begin
            flag_error($sformatf("context %0d rdy high before its chain end was queued", c));
        end
    endtask

    task automatic check_result(input int c);
        logic [DESC_WID-1:0] got;
        logic [DESC_WID-1:0] exp;
        got = '0;
        got[DESC_NXT_LSB +: PTR_WID]   = gather_buf_ptr[c*PTR_WID +: PTR_WID];
        got[DESC_EOF_BIT]              = gather_eof[c];
        got[DESC_SIZE_LSB +: SIZE_WID] = gather_size[c*SIZE_WID +: SIZE_WID];
        got[DESC_META_LSB +: META_WID] = gather_meta[c*META_WID +: META_WID];
        got[DESC_ERR_BIT]              = gather_err[c];
        results_seen++;
        if (model_count(c) == 0) begin
            flag_error($sformatf("context %0d returned a result no load asked for", c));
        end else begin
            exp = model_pop(c);
            if (got !== exp) begin
                errors++;
                $display("MISMATCH at %0t ns: context %0d result %h, expected %h",
                         $time, c, got, exp);
            end
        end
    endtask

    // Req stays up until rdy is seen, so a busy context sees req while rdy is low
    task automatic drive_load(input int c, input logic r);
        just_acc[c]   = 1'b0;
        gather_req[c] = 1'b0;
        if (load_idx[c] < load_cnt[c]) begin
            if (load_delay[c] > 0) begin
                load_delay[c]--;
            end else begin
                gather_req[c] = 1'b1;
                gather_ptr[c*PTR_WID +: PTR_WID] = load_start[c][load_idx[c]];
                if (r) begin
                    model_load(c, load_start[c][load_idx[c]]);
                    load_idx[c]++;
                    just_acc[c] = 1'b1;
                end
            end
        end
    endtask

    // Outputs are registered, so values seen at the falling edge hold through
    // the next rising edge where the handshakes complete
    task automatic cycle();
        logic [CONTEXTS-1:0] rdy_s;
        logic [CONTEXTS-1:0] vld_s;
        @(negedge clk);
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYC) begin
            $display("ERROR: timeout after %0d cycles, the chains never completed", cycle_cnt);
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            rdy_s   = gather_rdy;
            vld_s   = gather_vld;
            desc_wr = 1'b0;
            for (int c = 0; c < CONTEXTS; c++) begin
                drive_ack(c);
                check_rdy(c, rdy_s[c]);
                if (vld_s[c] && gather_ack[c]) begin
                    check_result(c);
                end
                drive_load(c, rdy_s[c]);
            end
        end
    endtask

    // ----------------------------------------
    // Chain setup
    // ----------------------------------------
    function automatic logic [PTR_WID-1:0] alloc_desc();
        logic [PTR_WID-1:0] a;
        a = PTR_WID'(rand_bits(PTR_WID));
        while (used[a]) begin
            a = a + PTR_WID'(1);
        end
        used[a] = 1'b1;
        return a;
    endfunction

    task automatic write_desc(input logic [PTR_WID-1:0] addr, input logic [DESC_WID-1:0] data);
        cycle();
        desc_wr      = 1'b1;
        desc_wr_addr = addr;
        desc_wr_data = data;
        model_write(addr, data);
    endtask

    task automatic build_chain(input int c, input int k, input int len);
        logic [PTR_WID-1:0]  addr [6];
        logic [DESC_WID-1:0] d;
        for (int i = 0; i < len; i++) begin
            addr[i] = alloc_desc();
        end
        for (int i = 0; i < len; i++) begin
            d = '0;
            d[DESC_NXT_LSB +: PTR_WID] = (i == len - 1) ? PTR_WID'(rand_bits(PTR_WID))
                                                        : addr[i+1];
            d[DESC_EOF_BIT]              = (i == len - 1);
            d[DESC_SIZE_LSB +: SIZE_WID] = SIZE_WID'(rand_bits(SIZE_WID));
            d[DESC_META_LSB +: META_WID] = META_WID'(rand_bits(META_WID));
            d[DESC_ERR_BIT]              = 1'(rand_bits(1));
            write_desc(addr[i], d);
        end
        load_start[c][k] = addr[0];
        load_cnt[c]      = k + 1;
    endtask

    task automatic start_test();
        err_start = errors;
        for (int a = 0; a < DESC_DEPTH; a++) begin
            used[a] = 1'b0;
        end
        for (int c = 0; c < CONTEXTS; c++) begin
            load_cnt[c]   = 0;
            load_idx[c]   = 0;
            load_delay[c] = 0;
            ack_mode[c]   = 0;
            ack_hold[c]   = 0;
        end
    endtask

    task automatic wait_done();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            cycle();
            busy = 1'b0;
            for (int c = 0; c < CONTEXTS; c++) begin
                if (load_idx[c] < load_cnt[c] || model_count(c) != 0) begin
                    busy = 1'b1;
                end
            end
        end
        // Any extra result shows up here with ack high
        for (int c = 0; c < CONTEXTS; c++) begin
            ack_mode[c] = 0;
            ack_hold[c] = 0;
        end
        repeat (SETTLE_CYC) cycle();
        if (gather_rdy != '1) begin
            flag_error("rdy stayed low after every chain had ended");
        end
    endtask

    task automatic report_test(input int n, input string name);
        if (errors == err_start) begin
            $display("test %0d %s: ok", n, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", n, name, errors - err_start);
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    initial begin : main
        int n;
        int victim;
        int seen;
        clk          = 1'b0;
        srst         = 1'b1;
        en           = 1'b1;
        gather_req   = '0;
        gather_ptr   = '0;
        gather_ack   = '0;
        desc_wr      = 1'b0;
        desc_wr_addr = '0;
        desc_wr_data = '0;
        lfsr         = 32'h73481034;
        cycle_cnt    = 0;
        errors       = 0;
        tests_failed = 0;
        results_seen = 0;
        just_acc     = '0;
        model_clear();

        // 1: reset and init
        start_test();
        n = 0;
        while (n < 10 || (!init_done && n < 10 + DESC_DEPTH + 8)) begin
            if (n == 10) begin
                srst = 1'b0;
            end
            cycle();
            if (gather_vld != '0 || gather_rdy != '0) begin
                flag_error("vld or rdy high during reset or init");
            end
            n++;
        end
        if (!init_done) begin
            flag_error("init_done never rose");
        end
        n = 0;
        while (gather_rdy != '1 && n < 4) begin
            cycle();
            n++;
        end
        if (gather_rdy != '1) begin
            flag_error("rdy did not rise after init");
        end
        report_test(1, "reset and init");

        // 2: single chain on context 0
        start_test();
        build_chain(0, 0, 1 + int'(rand_bits(3) % 6));
        wait_done();
        report_test(2, "single chain");

        // 3: two chains per context, second load requested while busy
        start_test();
        for (int c = 0; c < CONTEXTS; c++) begin
            load_delay[c] = int'(rand_bits(4));
            build_chain(c, 0, 1 + int'(rand_bits(3) % 6));
            build_chain(c, 1, 1 + int'(rand_bits(3) % 6));
        end
        wait_done();
        report_test(3, "concurrent contexts");

        // 4: random ack, one context blocked for a long stretch
        start_test();
        victim = int'(rand_bits(2));
        ack_hold[victim] = HOLD_CYC;
        for (int c = 0; c < CONTEXTS; c++) begin
            build_chain(c, 0, (c == victim) ? 6 : 1 + int'(rand_bits(3) % 6));
            ack_mode[c] = 1;
        end
        while (ack_hold[victim] > 0) begin
            cycle();
        end
        for (int c = 0; c < CONTEXTS; c++) begin
            if (c != victim && (load_idx[c] < load_cnt[c] || model_count(c) != 0)) begin
                flag_error($sformatf("context %0d stalled behind blocked context %0d", c, victim));
            end
        end
        wait_done();
        report_test(4, "back-pressure");

        // 5: en dropped after the first result
        start_test();
        for (int c = 0; c < CONTEXTS; c++) begin
            build_chain(c, 0, 6);
        end
        seen = results_seen;
        while (results_seen == seen) begin
            cycle();
        end
        en = 1'b0;
        repeat (SETTLE_CYC) cycle();
        seen = results_seen;
        repeat (40) cycle();
        if (results_seen != seen || gather_vld != '0) begin
            flag_error("results kept coming while en was low");
        end
        en = 1'b1;
        wait_done();
        report_test(5, "enable");

        $display("tests run 5, tests with errors %0d, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_gather

/* project.f */
+incdir+testbench
logic/gather_pkg.sv
logic/gather_if.sv
logic/desc_rd_if.sv
logic/ctxt_fifo.sv
logic/rr_arbiter.sv
logic/desc_mem.sv
logic/alloc_gather_core.sv
logic/gather_top.sv
testbench/tb_gather.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_gather -f project.f -o tb_gather
./obj_dir/tb_gather > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
